// ==== all.f ====
+incdir+src
src/csr_pkg.sv
src/csr_alu.sv
src/trap_ctrl.sv
src/csr_file.sv
src/csr_unit.sv
sim/csr_unit_asserts.sv
sim/tb_csr_unit.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CSR unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  -f all.f \
  --top-module tb_csr_unit \
  -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_csr_unit +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== sim/tb_csr_unit.sv ====
// Testbench for the CSR unit with LFSR stimulus, reference model and checks
`timescale 1ns/10ps
`include "csr_consts.svh"

module tb_csr_unit
  import csr_pkg::*;
();

  localparam int RESET_CYCLES = 8;
  localparam int N_RANDOM     = 300;
  localparam int N_ILLEGAL    = 80;
  localparam int N_TRAPS      = 20;
  localparam int N_MRET       = 20;
  localparam int N_BOTH       = 10;
  localparam int N_CYCLE      = 10;
  // Reset, phases 1 to 6 and margin
  localparam int CYCLE_LIMIT = RESET_CYCLES + 14 + N_RANDOM + N_ILLEGAL + N_TRAPS * 8 +
                               N_MRET * 3 + N_BOTH * 3 + N_CYCLE * 18 + 100;

  logic        clk;
  logic        rst;
  logic        csr_valid;
  csr_op_e     csr_op;
  logic [11:0] csr_addr;
  word_t       csr_src;
  word_t       csr_rdata;
  logic        csr_illegal;
  logic        trap_valid;
  word_t       trap_cause;
  word_t       trap_epc;
  word_t       trap_tval;
  logic        mret_valid;
  logic        redirect_valid;
  word_t       redirect_pc;

  // Reference model state
  word_t m_mstatus;
  word_t m_mie;
  word_t m_mtvec;
  word_t m_mscratch;
  word_t m_mepc;
  word_t m_mcause;
  word_t m_mtval;
  word_t m_mip;
  word_t m_mcycle;

  logic [15:0] lfsr = 16'd37965;
  int          word_errors = 0;
  int          flag_errors = 0;
  int          cycle_count = 0;
  logic [11:0] wr_addrs [9];
  logic [11:0] ro_addrs [5];

  csr_unit i_dut (.*);

  bind csr_unit csr_unit_asserts i_asserts (
    .clk            (clk),
    .rst            (rst),
    .csr_illegal    (csr_illegal),
    .trap_valid     (trap_valid),
    .mret_valid     (mret_valid),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .mstatus        (mstatus),
    .mtvec          (mtvec),
    .mepc           (mepc),
    .mie            (i_csr_file.mie),
    .mscratch       (i_csr_file.mscratch),
    .mcause         (i_csr_file.mcause),
    .mtval          (i_csr_file.mtval),
    .mip            (i_csr_file.mip)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failures found");
      $finish;
    end
  end

  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function logic lfsr_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) lfsr = lfsr ^ 16'hB400;
    return out;
  endfunction

  function logic [63:0] rand_bits(int n);
    logic [63:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[62:0], lfsr_bit()};
    end
    return val;
  endfunction

  function logic is_known(logic [11:0] addr);
    case (addr)
      ADDR_MSTATUS, ADDR_MIE, ADDR_MTVEC, ADDR_MSCRATCH, ADDR_MEPC,
      ADDR_MCAUSE, ADDR_MTVAL, ADDR_MIP, ADDR_MCYCLE,
      ADDR_MISA, ADDR_MVENDORID, ADDR_MARCHID, ADDR_MIMPID, ADDR_MHARTID: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function logic is_ro(logic [11:0] addr);
    case (addr)
      ADDR_MISA, ADDR_MVENDORID, ADDR_MARCHID, ADDR_MIMPID, ADDR_MHARTID: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function word_t model_read(logic [11:0] addr);
    case (addr)
      ADDR_MSTATUS:  return m_mstatus;
      ADDR_MIE:      return m_mie;
      ADDR_MTVEC:    return m_mtvec;
      ADDR_MSCRATCH: return m_mscratch;
      ADDR_MEPC:     return m_mepc;
      ADDR_MCAUSE:   return m_mcause;
      ADDR_MTVAL:    return m_mtval;
      ADDR_MIP:      return m_mip;
      ADDR_MCYCLE:   return m_mcycle;
      ADDR_MISA:     return `MISA_VALUE;
      default:       return '0; // Identity registers and unknown addresses
    endcase
  endfunction

  task check_word(string what, word_t got, word_t exp);
    if (got !== exp) begin
      word_errors++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task check_flag(string what, logic got, logic exp);
    if (got !== exp) begin
      flag_errors++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // One cycle: drive, check at the falling edge, then advance the model
  task step(logic v, csr_op_e op, logic [11:0] addr, word_t src,
            logic tv, word_t cause, word_t epc, word_t tval, logic mv);
    word_t old_val;
    word_t new_val;
    logic  wen;
    logic  ill;
    @(posedge clk);
    csr_valid  <= v;
    csr_op     <= op;
    csr_addr   <= addr;
    csr_src    <= src;
    trap_valid <= tv;
    trap_cause <= cause;
    trap_epc   <= epc;
    trap_tval  <= tval;
    mret_valid <= mv;
    @(negedge clk);
    old_val = model_read(addr);
    wen = v && (op == CSR_RW || src != '0);
    ill = v && (!is_known(addr) || (is_ro(addr) && wen));
    case (op)
      CSR_RS:  new_val = old_val | src;
      CSR_RC:  new_val = old_val & ~src;
      default: new_val = src;
    endcase
    if (v) check_word("csr_rdata", csr_rdata, old_val);
    check_flag("csr_illegal", csr_illegal, ill);
    check_flag("redirect_valid", redirect_valid, tv || mv);
    if (tv) check_word("trap redirect_pc", redirect_pc, {m_mtvec[63:2], 2'b00});
    else if (mv) check_word("mret redirect_pc", redirect_pc, m_mepc);
    m_mcycle = m_mcycle + 64'd1;
    if (tv) begin
      m_mstatus[`MSTATUS_MPIE_BIT] = m_mstatus[`MSTATUS_MIE_BIT];
      m_mstatus[`MSTATUS_MIE_BIT]  = 1'b0;
      m_mstatus[`MSTATUS_MPP_LO+1:`MSTATUS_MPP_LO] = 2'b11;
      m_mepc   = epc;
      m_mcause = cause;
      m_mtval  = tval;
    end else if (mv) begin
      m_mstatus[`MSTATUS_MIE_BIT]  = m_mstatus[`MSTATUS_MPIE_BIT];
      m_mstatus[`MSTATUS_MPIE_BIT] = 1'b1;
      m_mstatus[`MSTATUS_MPP_LO+1:`MSTATUS_MPP_LO] = 2'b11;
    end else if (wen && !ill) begin
      case (addr)
        ADDR_MSTATUS:  m_mstatus  = new_val;
        ADDR_MIE:      m_mie      = new_val;
        ADDR_MTVEC:    m_mtvec    = new_val;
        ADDR_MSCRATCH: m_mscratch = new_val;
        ADDR_MEPC:     m_mepc     = new_val;
        ADDR_MCAUSE:   m_mcause   = new_val;
        ADDR_MTVAL:    m_mtval    = new_val;
        ADDR_MIP:      m_mip      = new_val;
        ADDR_MCYCLE:   m_mcycle   = new_val; // Replaces the increment
        default: ;
      endcase
    end
  endtask

  task read_csr(logic [11:0] addr);
    step(1'b1, CSR_RS, addr, '0, 1'b0, '0, '0, '0, 1'b0);
  endtask

  task write_csr(logic [11:0] addr, word_t val);
    step(1'b1, CSR_RW, addr, val, 1'b0, '0, '0, '0, 1'b0);
  endtask

  task idle_cycle();
    step(1'b0, CSR_RW, '0, '0, 1'b0, '0, '0, '0, 1'b0);
  endtask

  task random_op(logic [11:0] addr);
    logic [63:0] r;
    csr_op_e     op;
    word_t       src;
    r   = rand_bits(2);
    op  = (r[1:0] == 2'd0) ? CSR_RW : (r[1:0] == 2'd1) ? CSR_RS : CSR_RC;
    r   = rand_bits(2);
    src = (r[1:0] == 2'd0) ? '0 : rand_bits(64); // Zero source now and then
    step(1'b1, op, addr, src, 1'b0, '0, '0, '0, 1'b0);
  endtask

  initial begin
    logic [63:0] r;
    logic [11:0] addr;
    int          total;
    wr_addrs = '{ADDR_MSTATUS, ADDR_MIE, ADDR_MTVEC, ADDR_MSCRATCH, ADDR_MEPC,
                 ADDR_MCAUSE, ADDR_MTVAL, ADDR_MIP, ADDR_MCYCLE};
    ro_addrs = '{ADDR_MISA, ADDR_MVENDORID, ADDR_MARCHID, ADDR_MIMPID, ADDR_MHARTID};
    rst <= 1'b1;
    csr_valid <= 1'b0;
    csr_op <= CSR_RW;
    csr_addr <= '0;
    csr_src <= '0;
    trap_valid <= 1'b0;
    trap_cause <= '0;
    trap_epc <= '0;
    trap_tval <= '0;
    mret_valid <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    m_mstatus = `MSTATUS_RESET;
    m_mie = `MIE_RESET;
    m_mtvec = '0;
    m_mscratch = '0;
    m_mepc = '0;
    m_mcause = '0;
    m_mtval = '0;
    m_mip = '0;
    m_mcycle = 64'd1; // Release cycle counts before the first operation

    // Reset values
    foreach (wr_addrs[i]) read_csr(wr_addrs[i]);
    foreach (ro_addrs[i]) read_csr(ro_addrs[i]);

    // Random operations on writable registers
    for (int i = 0; i < N_RANDOM; i++) begin
      r = rand_bits(4);
      random_op(wr_addrs[r[3:0] % 9]);
    end

    // Unknown addresses and read-only writes
    for (int i = 0; i < N_ILLEGAL; i++) begin
      r = rand_bits(1);
      if (r[0]) begin
        r = rand_bits(3);
        write_csr(ro_addrs[r[2:0] % 5], rand_bits(64));
      end else begin
        r = rand_bits(12);
        addr = r[11:0];
        while (is_known(addr)) begin
          r = rand_bits(12);
          addr = r[11:0];
        end
        random_op(addr);
      end
    end

    // Trap entry with a competing CSR write
    for (int i = 0; i < N_TRAPS; i++) begin
      write_csr(ADDR_MTVEC, rand_bits(64));
      write_csr(ADDR_MSTATUS, rand_bits(64));
      step(1'b1, CSR_RW, ADDR_MSCRATCH, rand_bits(64),
           1'b1, rand_bits(64), rand_bits(64), rand_bits(64), 1'b0);
      read_csr(ADDR_MEPC);
      read_csr(ADDR_MCAUSE);
      read_csr(ADDR_MTVAL);
      read_csr(ADDR_MSTATUS);
      read_csr(ADDR_MSCRATCH);
    end

    // mret, then trap and mret together
    for (int i = 0; i < N_MRET; i++) begin
      write_csr(ADDR_MSTATUS, rand_bits(64)); // Random MIE and MPIE before the return
      step(1'b0, CSR_RW, '0, '0, 1'b0, '0, '0, '0, 1'b1);
      read_csr(ADDR_MSTATUS);
    end
    for (int i = 0; i < N_BOTH; i++) begin
      step(1'b0, CSR_RW, '0, '0, 1'b1, rand_bits(64), rand_bits(64), rand_bits(64), 1'b1);
      read_csr(ADDR_MEPC);
      read_csr(ADDR_MSTATUS);
    end

    // Counter writes followed by a delayed read
    for (int i = 0; i < N_CYCLE; i++) begin
      write_csr(ADDR_MCYCLE, rand_bits(64));
      r = rand_bits(4);
      repeat (r[3:0]) idle_cycle();
      read_csr(ADDR_MCYCLE);
    end
    idle_cycle();

    total = word_errors + flag_errors + i_dut.i_asserts.fail_count;
    $display("Errors: %0d word, %0d flag, %0d assertion, %0d total",
             word_errors, flag_errors, i_dut.i_asserts.fail_count, total);
    if (total == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== sim/csr_unit_asserts.sv ====
// Concurrent assertions on CSR legality, redirect and reset behavior
`timescale 1ns/10ps

module csr_unit_asserts
  import csr_pkg::*;
(
  input logic  clk,
  input logic  rst,
  input logic  csr_illegal,
  input logic  trap_valid,
  input logic  mret_valid,
  input logic  redirect_valid,
  input word_t redirect_pc,
  input word_t mstatus,
  input word_t mtvec,
  input word_t mepc,
  input word_t mie,
  input word_t mscratch,
  input word_t mcause,
  input word_t mtval,
  input word_t mip
);

  int fail_count = 0;

  // Illegal access alone must not touch any register (mcycle runs freely)
  a_illegal_no_change: assert property (@(posedge clk) disable iff (rst)
    (csr_illegal && !trap_valid && !mret_valid) |=>
      ($stable(mstatus) && $stable(mtvec) && $stable(mepc) && $stable(mie) &&
       $stable(mscratch) && $stable(mcause) && $stable(mtval) && $stable(mip)))
    else begin
      fail_count = fail_count + 1;
      $error("illegal CSR access changed a register");
    end

  a_redirect_valid: assert property (@(posedge clk) disable iff (rst)
    redirect_valid == (trap_valid || mret_valid))
    else begin
      fail_count = fail_count + 1;
      $error("redirect_valid does not follow trap_valid or mret_valid");
    end

  a_trap_aligned: assert property (@(posedge clk) disable iff (rst)
    trap_valid |-> (redirect_pc[1:0] == 2'b00))
    else begin
      fail_count = fail_count + 1;
      $error("trap redirect target is not 4-byte aligned");
    end

  a_reset_quiet: assert property (@(posedge clk) rst |-> !redirect_valid)
    else begin
      fail_count = fail_count + 1;
      $error("redirect_valid high during reset");
    end

endmodule

// ==== src/csr_unit.sv ====
// CSR unit top with the CSR ALU, trap controller and machine CSR file
`timescale 1ns/10ps

module csr_unit
  import csr_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        csr_valid,
  input  csr_op_e     csr_op,
  input  logic [11:0] csr_addr,
  input  word_t       csr_src,
  output word_t       csr_rdata,
  output logic        csr_illegal,
  input  logic        trap_valid,
  input  word_t       trap_cause,
  input  word_t       trap_epc,
  input  word_t       trap_tval,
  input  logic        mret_valid,
  output logic        redirect_valid,
  output word_t       redirect_pc
);

  logic  alu_wen;
  word_t alu_wdata;
  logic  excp_enter;
  logic  excp_exit;
  word_t mstatus_next;
  word_t mepc_next;
  word_t mcause_next;
  word_t mtval_next;
  word_t mstatus;
  word_t mtvec;
  word_t mepc;

  csr_alu i_csr_alu (
    .csr_valid (csr_valid),
    .csr_op    (csr_op),
    .csr_src   (csr_src),
    .old_data  (csr_rdata), // Old value from the read port
    .alu_wen   (alu_wen),
    .alu_wdata (alu_wdata)
  );

  trap_ctrl i_trap_ctrl (
    .trap_valid     (trap_valid),
    .trap_cause     (trap_cause),
    .trap_epc       (trap_epc),
    .trap_tval      (trap_tval),
    .mret_valid     (mret_valid),
    .mstatus        (mstatus),
    .mtvec          (mtvec),
    .mepc           (mepc),
    .excp_enter     (excp_enter),
    .excp_exit      (excp_exit),
    .mstatus_next   (mstatus_next),
    .mepc_next      (mepc_next),
    .mcause_next    (mcause_next),
    .mtval_next     (mtval_next),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  csr_file i_csr_file (
    .clk          (clk),
    .rst          (rst),
    .rd_addr      (csr_addr),
    .rd_data      (csr_rdata),
    .csr_valid    (csr_valid),
    .csr_illegal  (csr_illegal),
    .alu_wen      (alu_wen),
    .alu_wdata    (alu_wdata),
    .excp_enter   (excp_enter),
    .excp_exit    (excp_exit),
    .mstatus_next (mstatus_next),
    .mepc_next    (mepc_next),
    .mcause_next  (mcause_next),
    .mtval_next   (mtval_next),
    .mstatus      (mstatus),
    .mtvec        (mtvec),
    .mepc         (mepc)
  );

endmodule

// ==== src/csr_file.sv ====
// Machine CSR storage, address decode, legality check, read mux and cycle counter
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_file
  import csr_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic [11:0] rd_addr,
  output word_t       rd_data,
  input  logic        csr_valid,
  output logic        csr_illegal,
  input  logic        alu_wen,
  input  word_t       alu_wdata,
  input  logic        excp_enter,
  input  logic        excp_exit,
  input  word_t       mstatus_next,
  input  word_t       mepc_next,
  input  word_t       mcause_next,
  input  word_t       mtval_next,
  output word_t       mstatus,
  output word_t       mtvec,
  output word_t       mepc
);

  word_t mie;
  word_t mscratch;
  word_t mcause;
  word_t mtval;
  word_t mip;
  word_t mcycle;

  logic addr_known; // Address maps to an implemented register
  logic addr_ro;    // Address maps to a read-only register
  logic wr_ok;      // Instruction write survives legality and trap priority

  logic wr_mstatus;
  logic wr_mie;
  logic wr_mtvec;
  logic wr_mscratch;
  logic wr_mepc;
  logic wr_mcause;
  logic wr_mtval;
  logic wr_mip;
  logic wr_mcycle;

  // Read mux, returns the value held before this cycle's update
  always_comb begin
    rd_data    = '0;
    addr_known = 1'b1;
    addr_ro    = 1'b0;
    case (rd_addr)
      ADDR_MSTATUS:  rd_data = mstatus;
      ADDR_MIE:      rd_data = mie;
      ADDR_MTVEC:    rd_data = mtvec;
      ADDR_MSCRATCH: rd_data = mscratch;
      ADDR_MEPC:     rd_data = mepc;
      ADDR_MCAUSE:   rd_data = mcause;
      ADDR_MTVAL:    rd_data = mtval;
      ADDR_MIP:      rd_data = mip;
      ADDR_MCYCLE:   rd_data = mcycle; // Current count
      ADDR_MISA: begin
        rd_data = `MISA_VALUE;
        addr_ro = 1'b1;
      end
      ADDR_MVENDORID, ADDR_MARCHID, ADDR_MIMPID, ADDR_MHARTID: begin
        addr_ro = 1'b1; // Identity registers read as zero
      end
      default: addr_known = 1'b0;
    endcase
  end

  // Unknown address, or a real write attempt to a read-only one
  assign csr_illegal = csr_valid & (~addr_known | (addr_ro & alu_wen));

  // Trap entry and mret both take precedence over the instruction
  assign wr_ok = alu_wen & ~csr_illegal & ~excp_enter & ~excp_exit;

  assign wr_mstatus  = wr_ok & (rd_addr == ADDR_MSTATUS);
  assign wr_mie      = wr_ok & (rd_addr == ADDR_MIE);
  assign wr_mtvec    = wr_ok & (rd_addr == ADDR_MTVEC);
  assign wr_mscratch = wr_ok & (rd_addr == ADDR_MSCRATCH);
  assign wr_mepc     = wr_ok & (rd_addr == ADDR_MEPC);
  assign wr_mcause   = wr_ok & (rd_addr == ADDR_MCAUSE);
  assign wr_mtval    = wr_ok & (rd_addr == ADDR_MTVAL);
  assign wr_mip      = wr_ok & (rd_addr == ADDR_MIP);
  assign wr_mcycle   = wr_ok & (rd_addr == ADDR_MCYCLE);

  // mstatus changes on both trap entry and mret
  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= `MSTATUS_RESET;
    end else if (excp_enter | excp_exit) begin
      mstatus <= mstatus_next;
    end else if (wr_mstatus) begin
      mstatus <= alu_wdata;
    end
  end

  // Trap-captured registers, entry only
  always_ff @(posedge clk) begin
    if (rst) begin
      mepc   <= '0;
      mcause <= '0;
      mtval  <= '0;
    end else if (excp_enter) begin
      mepc   <= mepc_next;
      mcause <= mcause_next;
      mtval  <= mtval_next;
    end else begin
      if (wr_mepc)   mepc   <= alu_wdata;
      if (wr_mcause) mcause <= alu_wdata;
      if (wr_mtval)  mtval  <= alu_wdata;
    end
  end

  // Plain storage, written only by instructions
  always_ff @(posedge clk) begin
    if (rst) begin
      mie      <= `MIE_RESET;
      mtvec    <= '0;
      mscratch <= '0;
      mip      <= '0; // No interrupt sources drive this
    end else begin
      if (wr_mie)      mie      <= alu_wdata;
      if (wr_mtvec)    mtvec    <= alu_wdata;
      if (wr_mscratch) mscratch <= alu_wdata;
      if (wr_mip)      mip      <= alu_wdata;
    end
  end

  // Free-running cycle counter, a write replaces one increment
  always_ff @(posedge clk) begin
    if (rst) begin
      mcycle <= '0;
    end else if (wr_mcycle) begin
      mcycle <= alu_wdata;
    end else begin
      mcycle <= mcycle + `XLEN'd1;
    end
  end

endmodule

// ==== src/trap_ctrl.sv ====
// Trap entry and mret control, CSR update values and PC redirect
`timescale 1ns/10ps
`include "csr_consts.svh"

module trap_ctrl
  import csr_pkg::*;
(
  input  logic  trap_valid,
  input  word_t trap_cause,
  input  word_t trap_epc,
  input  word_t trap_tval,
  input  logic  mret_valid,
  input  word_t mstatus,
  input  word_t mtvec,
  input  word_t mepc,
  output logic  excp_enter,
  output logic  excp_exit,
  output word_t mstatus_next,
  output word_t mepc_next,
  output word_t mcause_next,
  output word_t mtval_next,
  output logic  redirect_valid,
  output word_t redirect_pc
);

  word_t trap_base;

  // Trap beats mret when both arrive together
  assign excp_enter = trap_valid;
  assign excp_exit  = mret_valid & ~trap_valid;

  // Direct mode only, the mode field is dropped
  assign trap_base = {mtvec[`XLEN-1:2], 2'b00};

  // mstatus update for entry or return
  always_comb begin
    mstatus_next = mstatus;
    if (excp_enter) begin
      mstatus_next[`MSTATUS_MPIE_BIT] = mstatus[`MSTATUS_MIE_BIT];
      mstatus_next[`MSTATUS_MIE_BIT]  = 1'b0;
      mstatus_next[`MSTATUS_MPP_LO+1:`MSTATUS_MPP_LO] = 2'b11; // Came from M-mode
    end else if (excp_exit) begin
      mstatus_next[`MSTATUS_MIE_BIT]  = mstatus[`MSTATUS_MPIE_BIT];
      mstatus_next[`MSTATUS_MPIE_BIT] = 1'b1;
      mstatus_next[`MSTATUS_MPP_LO+1:`MSTATUS_MPP_LO] = 2'b11; // Only M-mode exists
    end
  end

  // Captured on entry
  assign mepc_next   = trap_epc;
  assign mcause_next = trap_cause;
  assign mtval_next  = trap_tval;

  // Same-cycle redirect
  assign redirect_valid = trap_valid | mret_valid;
  assign redirect_pc    = trap_valid ? trap_base : mepc;

endmodule

// ==== src/csr_alu.sv ====
// CSR read-modify-write datapath for csrrw, csrrs and csrrc
`timescale 1ns/10ps

module csr_alu
  import csr_pkg::*;
(
  input  logic    csr_valid,
  input  csr_op_e csr_op,
  input  word_t   csr_src,
  input  word_t   old_data,
  output logic    alu_wen,
  output word_t   alu_wdata
);

  logic src_nonzero;

  // Set and clear with rs1 = x0 are pure reads
  assign src_nonzero = |csr_src;

  always_comb begin
    alu_wen   = 1'b0;
    alu_wdata = old_data;
    case (csr_op)
      CSR_RW: begin
        alu_wen   = csr_valid;
        alu_wdata = csr_src;
      end
      CSR_RS: begin
        alu_wen   = csr_valid & src_nonzero;
        alu_wdata = old_data | csr_src; // Set source bits
      end
      CSR_RC: begin
        alu_wen   = csr_valid & src_nonzero;
        alu_wdata = old_data & ~csr_src; // Clear source bits
      end
      default: begin
        // Unused encoding, no write
        alu_wen   = 1'b0;
        alu_wdata = old_data;
      end
    endcase
  end

endmodule

// ==== src/csr_pkg.sv ====
// Package with the CSR word type, CSR operation enum and CSR address enum
`include "csr_consts.svh"

package csr_pkg;

  typedef logic [`XLEN-1:0] word_t;

  // Encoded like funct3[1:0] of the csrr* instructions
  typedef enum logic [1:0] {
    CSR_RW = 2'b01,
    CSR_RS = 2'b10,
    CSR_RC = 2'b11
  } csr_op_e;

  typedef enum logic [11:0] {
    // Writable machine registers
    ADDR_MSTATUS   = 12'h300,
    ADDR_MIE       = 12'h304,
    ADDR_MTVEC     = 12'h305,
    ADDR_MSCRATCH  = 12'h340,
    ADDR_MEPC      = 12'h341,
    ADDR_MCAUSE    = 12'h342,
    ADDR_MTVAL     = 12'h343,
    ADDR_MIP       = 12'h344,
    ADDR_MCYCLE    = 12'hB00,
    // Read-only machine registers
    ADDR_MISA      = 12'h301,
    ADDR_MVENDORID = 12'hF11,
    ADDR_MARCHID   = 12'hF12,
    ADDR_MIMPID    = 12'hF13,
    ADDR_MHARTID   = 12'hF14
  } csr_addr_e;

endpackage

// ==== src/csr_consts.svh ====
// Word width, CSR reset values, misa encoding and mstatus field positions
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// Register width of the core
`define XLEN 64

// mstatus after reset with MPP = 3 and MPIE = 1
`define MSTATUS_RESET 64'h0000_0000_0000_1880

// mie after reset, machine-level enables
`define MIE_RESET 64'h0000_0000_0000_0888

// MXL = 2 (RV64) in bits 63:62, I extension in bit 8
`define MISA_VALUE 64'h8000_0000_0000_0100

// mstatus field positions
`define MSTATUS_MIE_BIT 3
`define MSTATUS_MPIE_BIT 7
`define MSTATUS_MPP_LO 11 // MPP is two bits, 12:11

`endif
